// ==== logic/video_pkg.sv ====
// Raster is fixed at 384x264 pixel periods with a 256x224 visible window; no scroll or flip
`default_nettype none

package video_pkg;

    typedef logic [8:0] hcount_t;
    typedef logic [8:0] vcount_t;

    // Horizontal raster positions in pixel periods
    localparam hcount_t h_total   = 9'd384;
    localparam hcount_t h_visible = 9'd256;
    localparam hcount_t hs_start  = 9'd300;
    localparam hcount_t hs_end    = 9'd318;

    // Vertical raster positions in lines
    localparam vcount_t v_total  = 9'd264;
    localparam vcount_t vb_end   = 9'd15;
    localparam vcount_t vb_start = 9'd239;
    localparam vcount_t vs_start = 9'd254;
    localparam vcount_t vs_end   = 9'd2;

    // Timing bundle shared by both layers and the mixer
    typedef struct packed {
        hcount_t hdump;
        vcount_t vdump;
        // Line being drawn by the sprite layer, one ahead of vdump
        vcount_t vrender;
        logic    lhbl;
        logic    lvbl;
        logic    hinit;
    } video_timing_t;

endpackage

`default_nettype wire

// ==== logic/gfx_pkg.sv ====
// Pixel, memory and CPU bus types; sprite pixel 0 is transparent, ROM pixel 0 in the top nibble
`default_nettype none

package gfx_pkg;

    typedef logic [3:0]  pixel_t;
    typedef logic [11:0] colour_t;
    // Layer bit on top, layer pixel below
    typedef logic [4:0]  pal_addr_t;
    // Tile code (9 bits) then row (3 bits)
    typedef logic [11:0] tile_addr_t;
    // Sprite code (8), row (4), half (1, left is 0)
    typedef logic [12:0] spr_addr_t;
    typedef logic [31:0] rom_word_t;

    typedef struct packed {
        logic [10:0] addr;
        logic [7:0]  dout;
        logic        rnw;
    } cpu_bus_t;

    localparam int n_sprites = 8;

    // Byte offsets within a 4-byte sprite descriptor
    localparam logic [1:0] spr_ofs_y    = 2'd0;
    localparam logic [1:0] spr_ofs_code = 2'd1;
    localparam logic [1:0] spr_ofs_attr = 2'd2;
    localparam logic [1:0] spr_ofs_x    = 2'd3;

    // Attribute byte bits
    localparam int attr_hflip = 0;
    localparam int attr_en    = 7;

endpackage

`default_nettype wire

// ==== logic/video_timer.sv ====
// Counters advance only on pxl_cen; all decoded outputs are registered and low until the first strobe
`timescale 1ns/1ps
`default_nettype none

module video_timer (
    input  wire logic                     clk,
    input  wire logic                     rst_n,
    input  wire logic                     pxl_cen,
    output video_pkg::video_timing_t      timing,
    output logic                          hs,
    output logic                          vs
);

    video_pkg::hcount_t h_next;
    video_pkg::vcount_t v_next;
    video_pkg::vcount_t v_render;

    always_comb begin
        if (timing.hdump == video_pkg::h_total - 9'd1)
            h_next = '0;
        else
            h_next = timing.hdump + 9'd1;

        // Line advances when the horizontal count wraps
        v_next = timing.vdump;
        if (h_next == '0)
            v_next = (timing.vdump == video_pkg::v_total - 9'd1) ? '0 : timing.vdump + 9'd1;

        v_render = (v_next == video_pkg::v_total - 9'd1) ? '0 : v_next + 9'd1;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            timing <= '0;
            hs     <= 1'b0;
            vs     <= 1'b0;
        end else if (pxl_cen) begin
            timing.hdump   <= h_next;
            timing.vdump   <= v_next;
            timing.vrender <= v_render;
            timing.lhbl    <= h_next < video_pkg::h_visible;
            timing.lvbl    <= v_next > video_pkg::vb_end && v_next <= video_pkg::vb_start;
            timing.hinit   <= h_next == '0;
            hs <= h_next >= video_pkg::hs_start && h_next < video_pkg::hs_end;
            // Vertical sync wraps through line 0
            vs <= v_next >= video_pkg::vs_start || v_next < video_pkg::vs_end;
        end
    end

endmodule

`default_nettype wire

// ==== logic/tile_layer.sv ====
// Tile ROM must hold its word from one clock after scr_addr changes; map is 32x32 with no scroll
`timescale 1ns/1ps
`default_nettype none

module tile_layer (
    input  wire logic                        clk,
    input  wire logic                        rst_n,
    input  wire logic                        pxl_cen,
    input  wire gfx_pkg::cpu_bus_t           cpu,
    input  wire logic                        vram_cs,
    output logic [7:0]                       vram_dout,
    input  wire video_pkg::video_timing_t    timing,
    output gfx_pkg::tile_addr_t              scr_addr,
    input  wire gfx_pkg::rom_word_t          scr_data,
    input  wire logic                        en,
    output gfx_pkg::pixel_t                  scr_pxl
);

    // Video RAM split in code and attribute banks
    logic [7:0] code_ram [1024];
    logic [7:0] attr_ram [1024];

    video_pkg::vcount_t fline;
    logic [4:0]         col;
    logic [9:0]         vidx;
    logic [7:0]         code_q;
    logic [7:0]         attr_q;
    gfx_pkg::rom_word_t shift;

    // In blank the next line's first tile is fetched, so use vrender there
    always_comb begin
        fline = timing.hdump[8] ? timing.vrender : timing.vdump;
        col   = timing.hdump[8] ? 5'd0 : timing.hdump[7:3] + 5'd1;
        vidx  = {fline[7:3], col};
    end

    // CPU port
    always_ff @(posedge clk) begin
        if (vram_cs && !cpu.rnw) begin
            if (cpu.addr[10])
                attr_ram[cpu.addr[9:0]] <= cpu.dout;
            else
                code_ram[cpu.addr[9:0]] <= cpu.dout;
        end
        if (vram_cs)
            vram_dout <= cpu.addr[10] ? attr_ram[cpu.addr[9:0]] : code_ram[cpu.addr[9:0]];
    end

    // Video port, stable for a whole 8-pixel fetch slot
    always_ff @(posedge clk) begin
        code_q <= code_ram[vidx];
        attr_q <= attr_ram[vidx];
    end

    // Pattern shifter, loaded on the last pixel of the previous tile
    always_ff @(posedge clk) begin
        if (pxl_cen) begin
            if (timing.hdump[2:0] == 3'd7)
                shift <= scr_data;
            else
                shift <= shift << 4;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            scr_addr <= '0;
            scr_pxl  <= '0;
        end else if (pxl_cen) begin
            // Mid-slot address leaves the ROM several clocks to answer
            if (timing.hdump[2:0] == 3'd3)
                scr_addr <= {attr_q[0], code_q, fline[2:0]};
            scr_pxl <= en ? shift[31:28] : '0;
        end
    end

endmodule

`default_nettype wire

// ==== logic/sprite_layer.sv ====
// Draws on every clock in hblank, so pxl_cen must be at most every other clock to fit 8 sprites
`timescale 1ns/1ps
`default_nettype none

module sprite_layer (
    input  wire logic                        clk,
    input  wire logic                        rst_n,
    input  wire logic                        pxl_cen,
    input  wire gfx_pkg::cpu_bus_t           cpu,
    input  wire logic                        obj_cs,
    output logic [7:0]                       obj_dout,
    input  wire video_pkg::video_timing_t    timing,
    output gfx_pkg::spr_addr_t               spr_addr,
    output logic                             spr_cs,
    input  wire gfx_pkg::rom_word_t          spr_data,
    input  wire logic                        en,
    output gfx_pkg::pixel_t                  obj_pxl
);

    typedef enum logic [1:0] {
        st_idle,
        st_check,
        st_fetch,
        st_draw
    } state_t;

    state_t state;

    logic [7:0]      obj_ram [32];
    // Two 256-pixel line buffers, bank in the top address bit
    gfx_pkg::pixel_t lbuf [512];

    logic [2:0]      idx;
    logic [2:0]      cnt;
    logic            half;
    logic            sel;
    logic            front;
    logic [7:0]      spr_y;
    logic [7:0]      spr_code;
    logic [7:0]      spr_attr;
    logic [7:0]      spr_x;
    logic [7:0]      dy;
    logic [8:0]      px;
    logic [2:0]      nib_idx;
    gfx_pkg::pixel_t nib;
    logic            wr_en;

    always_comb begin
        spr_y    = obj_ram[{idx, gfx_pkg::spr_ofs_y}];
        spr_code = obj_ram[{idx, gfx_pkg::spr_ofs_code}];
        spr_attr = obj_ram[{idx, gfx_pkg::spr_ofs_attr}];
        spr_x    = obj_ram[{idx, gfx_pkg::spr_ofs_x}];
        dy       = timing.vrender[7:0] - spr_y;
        px       = {1'b0, spr_x} + {5'd0, half, cnt};
        // Mirrored sprites read each word back to front
        nib_idx  = spr_attr[gfx_pkg::attr_hflip] ? ~cnt : cnt;
        nib      = spr_data[{~nib_idx, 2'b11} -: 4];
        // Front already follows the swap during the hinit period
        front    = sel ^ timing.hinit;
        // Occupied slots keep the lower-numbered sprite
        wr_en    = state == st_draw && nib != '0 && !px[8] &&
                   lbuf[{~front, px[7:0]}] == '0;
    end

    // CPU port
    always_ff @(posedge clk) begin
        if (obj_cs && !cpu.rnw)
            obj_ram[cpu.addr[4:0]] <= cpu.dout;
        if (obj_cs)
            obj_dout <= obj_ram[cpu.addr[4:0]];
    end

    // Display clears what it reads, drawing only happens in blank
    always_ff @(posedge clk) begin
        if (pxl_cen && timing.lhbl)
            lbuf[{front, timing.hdump[7:0]}] <= '0;
        else if (wr_en)
            lbuf[{~front, px[7:0]}] <= nib;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            obj_pxl <= '0;
            sel     <= 1'b0;
        end else if (pxl_cen) begin
            obj_pxl <= (en && timing.lhbl) ? lbuf[{front, timing.hdump[7:0]}] : '0;
            if (timing.hinit)
                sel <= ~sel;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= st_idle;
            idx      <= '0;
            cnt      <= '0;
            half     <= 1'b0;
            spr_cs   <= 1'b0;
            spr_addr <= '0;
        end else begin
            spr_cs <= 1'b0;
            case (state)
                st_idle: begin
                    // Start at the fall of lhbl
                    if (pxl_cen && timing.hdump == video_pkg::h_visible) begin
                        idx   <= '0;
                        state <= st_check;
                    end
                end
                st_check: begin
                    if (spr_attr[gfx_pkg::attr_en] && dy[7:4] == 4'd0) begin
                        spr_addr <= {spr_code, dy[3:0], spr_attr[gfx_pkg::attr_hflip]};
                        spr_cs   <= 1'b1;
                        half     <= 1'b0;
                        state    <= st_fetch;
                    end else if (idx == 3'(gfx_pkg::n_sprites - 1)) begin
                        state <= st_idle;
                    end else begin
                        idx <= idx + 3'd1;
                    end
                end
                st_fetch: begin
                    // ROM word is valid from the next clock on
                    cnt   <= '0;
                    state <= st_draw;
                end
                st_draw: begin
                    cnt <= cnt + 3'd1;
                    if (cnt == 3'd7) begin
                        if (!half) begin
                            half        <= 1'b1;
                            spr_addr[0] <= ~spr_addr[0];
                            spr_cs      <= 1'b1;
                            state       <= st_fetch;
                        end else if (idx == 3'(gfx_pkg::n_sprites - 1)) begin
                            state <= st_idle;
                        end else begin
                            idx   <= idx + 3'd1;
                            state <= st_check;
                        end
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== logic/color_mixer.sv ====
// Palette is only loaded through the programming port and has no reset contents
`timescale 1ns/1ps
`default_nettype none

module color_mixer (
    input  wire logic                        clk,
    input  wire logic                        rst_n,
    input  wire logic                        pxl_cen,
    input  wire video_pkg::video_timing_t    timing,
    input  wire gfx_pkg::pixel_t             scr_pxl,
    input  wire gfx_pkg::pixel_t             obj_pxl,
    input  wire logic [7:0]                  prog_data,
    input  wire logic [5:0]                  prog_addr,
    input  wire logic                        prom_en,
    output logic [3:0]                       red,
    output logic [3:0]                       green,
    output logic [3:0]                       blue,
    output logic                             lhbl_dly,
    output logic                             lvbl_dly
);

    // Green in the high nibble, red in the low one
    logic [7:0] pal_rg [32];
    logic [3:0] pal_b  [32];

    gfx_pkg::pal_addr_t pal_addr;
    gfx_pkg::colour_t   colour;
    logic               lhbl_d1;
    logic               lvbl_d1;

    // Any opaque sprite pixel wins over the tiles
    always_comb begin
        pal_addr = (obj_pxl != '0) ? {1'b1, obj_pxl} : {1'b0, scr_pxl};
        colour   = {pal_rg[pal_addr][3:0], pal_rg[pal_addr][7:4], pal_b[pal_addr]};
    end

    always_ff @(posedge clk) begin
        if (prom_en) begin
            if (prog_addr[0])
                pal_b[prog_addr[5:1]] <= prog_data[3:0];
            else
                pal_rg[prog_addr[5:1]] <= prog_data;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            lhbl_d1  <= 1'b0;
            lvbl_d1  <= 1'b0;
            lhbl_dly <= 1'b0;
            lvbl_dly <= 1'b0;
            {red, green, blue} <= '0;
        end else if (pxl_cen) begin
            lhbl_d1  <= timing.lhbl;
            lvbl_d1  <= timing.lvbl;
            lhbl_dly <= lhbl_d1;
            lvbl_dly <= lvbl_d1;
            {red, green, blue} <= (lhbl_d1 && lvbl_d1) ? colour : '0;
        end
    end

endmodule

`default_nettype wire

// ==== logic/video_top.sv ====
// Both graphics ROMs sit outside and answer one clock after the address; single clock domain
`timescale 1ns/1ps
`default_nettype none

module video_top (
    input  wire logic                   clk,
    input  wire logic                   rst_n,
    input  wire logic                   pxl_cen,
    // CPU bus
    input  wire logic [10:0]            cpu_addr,
    input  wire logic [7:0]             cpu_dout,
    input  wire logic                   cpu_rnw,
    input  wire logic                   vram_cs,
    input  wire logic                   obj_cs,
    output logic [7:0]                  vram_dout,
    output logic [7:0]                  obj_dout,
    // Palette programming
    input  wire logic [7:0]             prog_data,
    input  wire logic [5:0]             prog_addr,
    input  wire logic                   prom_en,
    // Graphics ROMs
    output gfx_pkg::tile_addr_t         scr_addr,
    input  wire gfx_pkg::rom_word_t     scr_data,
    output gfx_pkg::spr_addr_t          spr_addr,
    output logic                        spr_cs,
    input  wire gfx_pkg::rom_word_t     spr_data,
    // Bit 0 tiles, bit 1 sprites
    input  wire logic [1:0]             gfx_en,
    output logic                        hs,
    output logic                        vs,
    output logic                        lhbl_dly,
    output logic                        lvbl_dly,
    output logic [3:0]                  red,
    output logic [3:0]                  green,
    output logic [3:0]                  blue
);

    gfx_pkg::cpu_bus_t         cpu;
    video_pkg::video_timing_t  timing;
    gfx_pkg::pixel_t           scr_pxl;
    gfx_pkg::pixel_t           obj_pxl;

    assign cpu = {cpu_addr, cpu_dout, cpu_rnw};

    video_timer u_timer (
        .clk      ( clk      ),
        .rst_n    ( rst_n    ),
        .pxl_cen  ( pxl_cen  ),
        .timing   ( timing   ),
        .hs       ( hs       ),
        .vs       ( vs       )
    );

    tile_layer u_tiles (
        .clk       ( clk       ),
        .rst_n     ( rst_n     ),
        .pxl_cen   ( pxl_cen   ),
        .cpu       ( cpu       ),
        .vram_cs   ( vram_cs   ),
        .vram_dout ( vram_dout ),
        .timing    ( timing    ),
        .scr_addr  ( scr_addr  ),
        .scr_data  ( scr_data  ),
        .en        ( gfx_en[0] ),
        .scr_pxl   ( scr_pxl   )
    );

    sprite_layer u_sprites (
        .clk       ( clk       ),
        .rst_n     ( rst_n     ),
        .pxl_cen   ( pxl_cen   ),
        .cpu       ( cpu       ),
        .obj_cs    ( obj_cs    ),
        .obj_dout  ( obj_dout  ),
        .timing    ( timing    ),
        .spr_addr  ( spr_addr  ),
        .spr_cs    ( spr_cs    ),
        .spr_data  ( spr_data  ),
        .en        ( gfx_en[1] ),
        .obj_pxl   ( obj_pxl   )
    );

    color_mixer u_mixer (
        .clk       ( clk       ),
        .rst_n     ( rst_n     ),
        .pxl_cen   ( pxl_cen   ),
        .timing    ( timing    ),
        .scr_pxl   ( scr_pxl   ),
        .obj_pxl   ( obj_pxl   ),
        .prog_data ( prog_data ),
        .prog_addr ( prog_addr ),
        .prom_en   ( prom_en   ),
        .red       ( red       ),
        .green     ( green     ),
        .blue      ( blue      ),
        .lhbl_dly  ( lhbl_dly  ),
        .lvbl_dly  ( lvbl_dly  )
    );

endmodule

`default_nettype wire

// ==== tests/video_model.svh ====
// Expected video output; needs the testbench's ROM, video RAM, object RAM and palette shadows
`ifndef VIDEO_MODEL_SVH
`define VIDEO_MODEL_SVH

// Raster figures in pixel periods and lines
function automatic int line_period();
    return 384;
endfunction

function automatic int frame_lines();
    return 264;
endfunction

function automatic int visible_columns();
    return 256;
endfunction

function automatic int visible_lines();
    return 224;
endfunction

// Tile map is 32x32, row-major, attribute bit 0 is code bit 8
function automatic logic [3:0] tile_pixel(input logic [7:0] x, input logic [7:0] y);
    logic [9:0]  idx;
    logic [11:0] addr;
    logic [31:0] w;
    idx  = {y[7:3], x[7:3]};
    addr = {vram_attr[idx][0], vram_code[idx], y[2:0]};
    w    = scr_rom[addr];
    return w[31 - 4 * x[2:0] -: 4];
endfunction

// First enabled sprite with an opaque pixel here wins
function automatic logic [3:0] sprite_pixel(input logic [7:0] x, input logic [7:0] y);
    logic [7:0]  sy;
    logic [7:0]  code;
    logic [7:0]  attr;
    logic [7:0]  sx;
    logic [7:0]  dy;
    logic [2:0]  p;
    logic        half;
    logic [31:0] w;
    logic [3:0]  nib;
    int          jj;
    for (int i = 0; i < 8; i++) begin
        sy   = obj_mem[i * 4];
        code = obj_mem[i * 4 + 1];
        attr = obj_mem[i * 4 + 2];
        sx   = obj_mem[i * 4 + 3];
        dy   = y - sy;
        jj   = int'(x) - int'(sx);
        if (attr[7] && dy < 8'd16 && jj >= 0 && jj < 16) begin
            // Mirroring swaps both the half and the pixel order
            half = attr[0] ^ jj[3];
            p    = attr[0] ? ~jj[2:0] : jj[2:0];
            w    = spr_rom[{code, dy[3:0], half}];
            nib  = w[31 - 4 * p -: 4];
            if (nib != 4'd0)
                return nib;
        end
    end
    return 4'd0;
endfunction

function automatic logic [11:0] expected_colour(input logic [7:0] x, input logic [7:0] y,
                                                input logic [1:0] en);
    logic [3:0] t;
    logic [3:0] s;
    logic [4:0] a;
    t = en[0] ? tile_pixel(x, y) : 4'd0;
    s = en[1] ? sprite_pixel(x, y) : 4'd0;
    a = (s != 4'd0) ? {1'b1, s} : {1'b0, t};
    return {pal_rg[a][3:0], pal_rg[a][7:4], pal_b[a]};
endfunction

`endif

// ==== tests/tb_video_top.sv ====
// Runs whole frames at one pixel per two clocks; ROMs are random with a fixed seed
`timescale 1ns/1ps
`default_nettype none

module tb_video_top;

    logic                clk;
    logic                rst_n;
    logic                pxl_cen;
    logic [10:0]         cpu_addr;
    logic [7:0]          cpu_dout;
    logic                cpu_rnw;
    logic                vram_cs;
    logic                obj_cs;
    logic [7:0]          vram_dout;
    logic [7:0]          obj_dout;
    logic [7:0]          prog_data;
    logic [5:0]          prog_addr;
    logic                prom_en;
    gfx_pkg::tile_addr_t scr_addr;
    gfx_pkg::rom_word_t  scr_data;
    gfx_pkg::spr_addr_t  spr_addr;
    logic                spr_cs;
    gfx_pkg::rom_word_t  spr_data;
    logic [1:0]          gfx_en;
    logic                hs;
    logic                vs;
    logic                lhbl_dly;
    logic                lvbl_dly;
    logic [3:0]          red;
    logic [3:0]          green;
    logic [3:0]          blue;

    // ROM contents and shadow copies of the DUT memories
    logic [31:0] scr_rom [4096];
    logic [31:0] spr_rom [8192];
    logic [7:0]  vram_code [1024];
    logic [7:0]  vram_attr [1024];
    logic [7:0]  obj_mem [32];
    logic [7:0]  pal_rg [32];
    logic [3:0]  pal_b [32];

    int          seed = 47;
    string       test_name = "reset";
    bit          checking = 1'b0;
    logic        cen_q = 1'b0;
    logic [11:0] scr_addr_q;
    logic [12:0] spr_addr_q;
    logic        spr_req = 1'b0;

    // Raster tracking in the comparing process
    int   col = 0;
    int   line = 0;
    int   strobes = 0;
    int   lines = 0;
    int   vis_lines = 0;
    int   vs_rises = 0;
    int   pixels = 0;
    logic prev_hs = 1'b0;
    logic prev_vs = 1'b0;
    logic prev_lhbl = 1'b0;
    logic prev_lvbl = 1'b0;
    bit   hs_seen = 1'b0;
    bit   lhbl_fell = 1'b0;

    video_top u_video_top (
        .clk       ( clk       ),
        .rst_n     ( rst_n     ),
        .pxl_cen   ( pxl_cen   ),
        .cpu_addr  ( cpu_addr  ),
        .cpu_dout  ( cpu_dout  ),
        .cpu_rnw   ( cpu_rnw   ),
        .vram_cs   ( vram_cs   ),
        .obj_cs    ( obj_cs    ),
        .vram_dout ( vram_dout ),
        .obj_dout  ( obj_dout  ),
        .prog_data ( prog_data ),
        .prog_addr ( prog_addr ),
        .prom_en   ( prom_en   ),
        .scr_addr  ( scr_addr  ),
        .scr_data  ( scr_data  ),
        .spr_addr  ( spr_addr  ),
        .spr_cs    ( spr_cs    ),
        .spr_data  ( spr_data  ),
        .gfx_en    ( gfx_en    ),
        .hs        ( hs        ),
        .vs        ( vs        ),
        .lhbl_dly  ( lhbl_dly  ),
        .lvbl_dly  ( lvbl_dly  ),
        .red       ( red       ),
        .green     ( green     ),
        .blue      ( blue      )
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        pxl_cen = 1'b0;
        forever @(negedge clk) pxl_cen <= ~pxl_cen;
    end

    // ROMs latch the address on the rising edge and answer before the next one
    always @(posedge clk) begin
        cen_q      <= pxl_cen;
        scr_addr_q <= scr_addr;
        spr_addr_q <= spr_addr;
        spr_req    <= spr_cs;
    end

    always @(negedge clk) begin
        scr_data <= scr_rom[scr_addr_q];
        if (spr_req)
            spr_data <= spr_rom[spr_addr_q];
    end

    task automatic stop_run(input string reason);
        $display("%s", reason);
        $display("STATUS: FAIL");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_value(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual)
            stop_run($sformatf("error: %s %s expected %0h actual %0h",
                               test_name, what, expected, actual));
    endtask

    task automatic wait_vs_rise();
        int   n;
        logic prev;
        bit   done;
        n    = 0;
        prev = vs;
        done = 1'b0;
        while (!done) begin
            @(negedge clk);
            if (vs && !prev) begin
                done = 1'b1;
            end else begin
                prev = vs;
                n++;
                if (n > 300000)
                    stop_run("timeout: no rising edge on vs within a frame");
            end
        end
    endtask

    task automatic cpu_write(input bit obj, input logic [10:0] addr, input logic [7:0] data);
        @(negedge clk);
        cpu_addr = addr;
        cpu_dout = data;
        cpu_rnw  = 1'b0;
        vram_cs  = !obj;
        obj_cs   = obj;
        if (obj)
            obj_mem[addr[4:0]] = data;
        else if (addr[10])
            vram_attr[addr[9:0]] = data;
        else
            vram_code[addr[9:0]] = data;
        @(negedge clk);
        vram_cs = 1'b0;
        obj_cs  = 1'b0;
        cpu_rnw = 1'b1;
    endtask

    task automatic cpu_read(input bit obj, input logic [10:0] addr, output logic [7:0] data);
        @(negedge clk);
        cpu_addr = addr;
        cpu_rnw  = 1'b1;
        vram_cs  = !obj;
        obj_cs   = obj;
        @(negedge clk);
        data    = obj ? obj_dout : vram_dout;
        vram_cs = 1'b0;
        obj_cs  = 1'b0;
    endtask

    task automatic load_palette();
        logic [7:0] d;
        for (int i = 0; i < 64; i++) begin
            @(negedge clk);
            d         = 8'($random(seed));
            prog_addr = 6'(i);
            prog_data = d;
            prom_en   = 1'b1;
            if (i % 2 == 1)
                pal_b[i / 2] = d[3:0];
            else
                pal_rg[i / 2] = d;
        end
        @(negedge clk);
        prom_en = 1'b0;
    endtask

    // Check one whole frame from one vs rise to the next
    task automatic run_frame(input string name);
        test_name = name;
        wait_vs_rise();
        pixels   = 0;
        checking = 1'b1;
        wait_vs_rise();
        checking = 1'b0;
        check_value("checked pixels", visible_columns() * visible_lines(), pixels);
    endtask

    task automatic set_sprite(input int i, input logic [7:0] y, input logic [7:0] attr,
                              input logic [7:0] x);
        cpu_write(1'b1, 11'(i * 4), y);
        cpu_write(1'b1, 11'(i * 4 + 1), 8'($random(seed)));
        cpu_write(1'b1, 11'(i * 4 + 2), attr);
        cpu_write(1'b1, 11'(i * 4 + 3), x);
    endtask

    // Comparing process samples once per pixel strobe
    always @(negedge clk) begin
        if (cen_q) begin
            strobes++;
            if (hs && !prev_hs) begin
                if (hs_seen)
                    check_value("strobes per line", line_period(), strobes);
                hs_seen = 1'b1;
                strobes = 0;
                lines++;
            end
            if (vs && !prev_vs) begin
                // Vs first rises on line 0 after reset and next ends a partial frame
                if (vs_rises >= 2)
                    check_value("lines per frame", frame_lines(), lines);
                vs_rises++;
                lines = 0;
            end
            if (lvbl_dly && !prev_lvbl) begin
                line      = 16;
                vis_lines = 0;
            end
            if (!lvbl_dly && prev_lvbl)
                check_value("visible lines", visible_lines(), vis_lines);
            if (lhbl_dly) begin
                if (checking && lvbl_dly) begin
                    check_value($sformatf("pixel x=%0d y=%0d", col, line),
                                expected_colour(col[7:0], line[7:0], gfx_en),
                                {red, green, blue});
                    pixels++;
                end
                col++;
            end
            if (!lhbl_dly && prev_lhbl) begin
                // The line after reset starts one column late
                if (lhbl_fell)
                    check_value("visible columns", visible_columns(), col);
                lhbl_fell = 1'b1;
                col       = 0;
                if (lvbl_dly) begin
                    vis_lines++;
                    line++;
                end
            end
            if (!(lhbl_dly && lvbl_dly))
                check_value("blanked rgb", 0, {red, green, blue});
            prev_hs   = hs;
            prev_vs   = vs;
            prev_lhbl = lhbl_dly;
            prev_lvbl = lvbl_dly;
        end
    end

    initial begin
        logic [10:0] addr_q[$];
        logic [7:0]  rd;
        logic [10:0] a;

        rst_n     = 1'b0;
        cpu_addr  = '0;
        cpu_dout  = '0;
        cpu_rnw   = 1'b1;
        vram_cs   = 1'b0;
        obj_cs    = 1'b0;
        prog_data = '0;
        prog_addr = '0;
        prom_en   = 1'b0;
        scr_data  = '0;
        spr_data  = '0;
        gfx_en    = 2'b00;
        for (int i = 0; i < 4096; i++)
            scr_rom[i] = $random(seed);
        for (int i = 0; i < 8192; i++)
            spr_rom[i] = $random(seed);
        repeat (2) @(negedge clk);
        rst_n = 1'b1;

        // Raster timing and blanking over two frames
        test_name = "raster";
        load_palette();
        wait_vs_rise();
        wait_vs_rise();
        wait_vs_rise();

        test_name = "cpu_access";
        for (int i = 0; i < 40; i++) begin
            a = 11'($random(seed));
            addr_q.push_back(a);
            cpu_write(1'b0, a, 8'($random(seed)));
        end
        foreach (addr_q[i]) begin
            cpu_read(1'b0, addr_q[i], rd);
            check_value("video ram read",
                        addr_q[i][10] ? vram_attr[addr_q[i][9:0]] : vram_code[addr_q[i][9:0]],
                        rd);
        end
        addr_q.delete();
        for (int i = 0; i < 32; i++) begin
            a = 11'($random(seed) & 31);
            addr_q.push_back(a);
            cpu_write(1'b1, a, 8'($random(seed)));
        end
        foreach (addr_q[i]) begin
            cpu_read(1'b1, addr_q[i], rd);
            check_value("object ram read", obj_mem[addr_q[i][4:0]], rd);
        end

        // Full random tile map with sprites off
        for (int i = 0; i < 2048; i++)
            cpu_write(1'b0, 11'(i), 8'($random(seed)));
        for (int i = 0; i < 8; i++)
            cpu_write(1'b1, 11'(i * 4 + 2), 8'h00);
        gfx_en = 2'b01;
        run_frame("tile_frame");

        // Overlap, mirroring, right-edge clip and top partial
        set_sprite(0, 8'd40, 8'h80, 8'd60);
        set_sprite(1, 8'd48, 8'h81, 8'd66);
        set_sprite(2, 8'd100, 8'h80, 8'd248);
        set_sprite(3, 8'd8, 8'h81, 8'd0);
        set_sprite(4, 8'd120, 8'h80, 8'd120);
        set_sprite(5, 8'd124, 8'h81, 8'd124);
        set_sprite(6, 8'd200, 8'h80, 8'd10);
        set_sprite(7, 8'd230, 8'h81, 8'd200);
        gfx_en = 2'b11;
        run_frame("sprites_over_tiles");

        cpu_write(1'b1, 11'(4 * 4 + 2), 8'h00);
        gfx_en = 2'b10;
        run_frame("layer_enables");

        $display("STATUS: PASS");
        $finish;
    end

`include "video_model.svh"

endmodule

`default_nettype wire

// ==== sources.f ====
+incdir+tests
logic/video_pkg.sv
logic/gfx_pkg.sv
logic/video_timer.sv
logic/tile_layer.sv
logic/sprite_layer.sv
logic/color_mixer.sv
logic/video_top.sv
tests/tb_video_top.sv

// ==== Makefile ====
SIM      = verilator
FLAGS    = --timing -Wno-fatal
TOP      = tb_video_top
FILELIST = sources.f
OBJDIR   = obj_dir
PASS     = STATUS: PASS

.PHONY: all lint sim clean

all: sim

lint:
	$(SIM) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(SIM) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) -o $(TOP)
	./$(OBJDIR)/$(TOP) | tee /dev/stderr | grep -q "$(PASS)"

clean:
	rm -rf $(OBJDIR)
